// ==== tb.f ====
source/isa_pkg.sv
source/ooo_pkg.sv
source/inst_buffer.sv
source/dispatch.sv
source/map_table.sv
source/free_list.sv
source/rob.sv
source/rename_core.sv
sim/rename_core_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP        = rename_core_tb
FILELIST   = tb.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Some tests failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "$(FAIL_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/rename_core_tb.sv ====
// testbench for the rename core: random groups and completions checked against a reference model
`timescale 1ns/10ps

module rename_core_tb import isa_pkg::*, ooo_pkg::*; ();

    localparam int phys_regs   = 16;
    localparam int rob_depth   = 8;
    localparam int ib_depth    = 4;
    localparam int preg_w      = $clog2(phys_regs);
    localparam int idx_w       = $clog2(rob_depth);
    localparam int run_cycles  = 2000;
    localparam int drain_limit = 500;                    // cycles allowed to empty the core

    logic                          clock;
    logic                          reset;
    count_t                        in_count;
    opcode_t   [width-1:0]         in_opcode;
    arch_idx_t [width-1:0]         in_dest, in_src1, in_src2;
    count_t                        ib_open;
    logic      [width-1:0]         complete_valid;
    logic      [width-1:0][idx_w-1:0] complete_rob_idx;
    count_t                        dis_count;
    opcode_t   [width-1:0]         dis_opcode;
    logic      [width-1:0][preg_w-1:0] dis_phys_src1, dis_phys_src2;
    logic      [width-1:0][preg_w-1:0] dis_phys_dest, dis_phys_old;
    logic      [width-1:0][idx_w-1:0] dis_rob_idx;
    count_t                        ret_count;
    logic      [width-1:0]         ret_has_dest;
    arch_idx_t [width-1:0]         ret_arch_dest;
    logic      [width-1:0][preg_w-1:0] ret_phys_dest, ret_phys_old;

    //////////////////////////////////////////////////
    // reference model state

    opcode_t     ib_op [$];                              // undispatched, oldest first
    int          ib_dst [$];
    int          ib_s1 [$];
    int          ib_s2 [$];
    int          model_map [arch_regs];
    int          free_q [$];
    int          rob_order [$];                          // rob indices, oldest first
    bit          rob_has [rob_depth];
    int          rob_arch [rob_depth];
    int          rob_pd [rob_depth];
    int          rob_po [rob_depth];
    bit          rob_done [rob_depth];
    int          rob_tail;
    int unsigned rng_state;
    int          errors, checks;
    int          accepted, dispatched, retired, pops;   // dispatched and retired seen on the dut
    bit          saw_full, saw_stall;

    rename_core #(.phys_regs(phys_regs), .rob_depth(rob_depth), .ib_depth(ib_depth)) UUT (
        .clock(clock), .reset(reset),
        .in_count(in_count), .in_opcode(in_opcode), .in_dest(in_dest),
        .in_src1(in_src1), .in_src2(in_src2), .ib_open(ib_open),
        .complete_valid(complete_valid), .complete_rob_idx(complete_rob_idx),
        .dis_count(dis_count), .dis_opcode(dis_opcode),
        .dis_phys_src1(dis_phys_src1), .dis_phys_src2(dis_phys_src2),
        .dis_phys_dest(dis_phys_dest), .dis_phys_old(dis_phys_old), .dis_rob_idx(dis_rob_idx),
        .ret_count(ret_count), .ret_has_dest(ret_has_dest), .ret_arch_dest(ret_arch_dest),
        .ret_phys_dest(ret_phys_dest), .ret_phys_old(ret_phys_old)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;                      // 40 ns period
    end

    function automatic int unsigned xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // alu, mul and load produce a register
    function automatic bit has_result(opcode_t op);
        return (op == op_alu) || (op == op_mul) || (op == op_load);
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error: %s at %0t", what, $time);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus, driven just after the edge

    task automatic drive_inputs(input bit feed, input int comp_pct);
        int room;
        int pick;
        int pending [$];

        room = ib_depth - ib_op.size();
        if (room > width)
            room = width;
        in_count = feed ? count_t'(xorshift32() % (room + 1)) : '0;
        for (int i = 0; i < width; i++) begin
            in_opcode[i] = opcode_t'(xorshift32() % 5);
            in_dest[i]   = arch_idx_t'(xorshift32());
            in_src1[i]   = arch_idx_t'(xorshift32());
            in_src2[i]   = arch_idx_t'(xorshift32());
        end
        foreach (rob_order[k])
            if (!rob_done[rob_order[k]])
                pending.push_back(rob_order[k]);         // still executing
        for (int i = 0; i < width; i++) begin
            complete_valid[i]   = 1'b0;
            complete_rob_idx[i] = '0;
            if (pending.size() > 0 && int'(xorshift32() % 100) < comp_pct) begin
                pick = int'(xorshift32() % pending.size());
                complete_valid[i]   = 1'b1;
                complete_rob_idx[i] = idx_w'(pending[pick]);
                pending.delete(pick);                    // no double completion
            end
        end
    endtask

    //////////////////////////////////////////////////
    // mid-cycle compare, then advance model past the edge

    task automatic check_and_step();
        int room, rob_room, n_dis, n_ret, take, dest, e;

        room = ib_depth - ib_op.size();
        check_value("ib_open", ib_open, (room > width) ? width : room);

        // in-order limit from buffer, rob room and free regs
        rob_room = rob_depth - rob_order.size();
        n_dis = 0;
        take  = 0;
        for (int i = 0; i < width; i++) begin
            if (n_dis == i && i < ib_op.size() && i < rob_room &&
                take + int'(has_result(ib_op[i])) <= free_q.size()) begin
                n_dis++;
                take += int'(has_result(ib_op[i]));
            end
        end
        check_value("dis_count", dis_count, n_dis);
        if (n_dis == 0 && ib_op.size() > 0)
            saw_stall = 1'b1;

        // retirement looks at the rob before this cycle's writes
        n_ret = 0;
        for (int i = 0; i < width; i++)
            if (n_ret == i && i < rob_order.size() && rob_done[rob_order[i]])
                n_ret++;
        check_value("ret_count", ret_count, n_ret);
        for (int i = 0; i < n_ret; i++) begin
            e = rob_order[i];
            check_value("ret_has_dest", ret_has_dest[i], rob_has[e]);
            if (rob_has[e]) begin
                check_value("ret_arch_dest", ret_arch_dest[i], rob_arch[e]);
                check_value("ret_phys_dest", ret_phys_dest[i], rob_pd[e]);
                check_value("ret_phys_old", ret_phys_old[i], rob_po[e]);
            end
        end
        retired += int'(ret_count);

        // slot 0 updates the map first, so slot 1 sees its new tag
        for (int i = 0; i < n_dis; i++) begin
            check_value("dis_opcode", dis_opcode[i], ib_op[i]);
            check_value("dis_phys_src1", dis_phys_src1[i], model_map[ib_s1[i]]);
            check_value("dis_phys_src2", dis_phys_src2[i], model_map[ib_s2[i]]);
            check_value("dis_rob_idx", dis_rob_idx[i], rob_tail);
            dest = 0;
            rob_po[rob_tail] = 0;
            if (has_result(ib_op[i])) begin
                dest = free_q.pop_front();               // fifo hand-out
                pops++;
                check_value("dis_phys_dest", dis_phys_dest[i], dest);
                check_value("dis_phys_old", dis_phys_old[i], model_map[ib_dst[i]]);
                rob_po[rob_tail] = model_map[ib_dst[i]];
                model_map[ib_dst[i]] = dest;
            end
            rob_has[rob_tail]  = has_result(ib_op[i]);
            rob_arch[rob_tail] = ib_dst[i];
            rob_pd[rob_tail]   = dest;
            rob_done[rob_tail] = 1'b0;
            rob_order.push_back(rob_tail);
            rob_tail = (rob_tail + 1) % rob_depth;
        end

        for (int i = 0; i < n_ret; i++) begin
            e = rob_order.pop_front();
            if (rob_has[e])
                free_q.push_back(rob_po[e]);             // told back to the pool
        end
        for (int i = 0; i < width; i++)
            if (complete_valid[i])
                rob_done[complete_rob_idx[i]] = 1'b1;

        for (int i = 0; i < n_dis; i++) begin
            void'(ib_op.pop_front());
            void'(ib_dst.pop_front());
            void'(ib_s1.pop_front());
            void'(ib_s2.pop_front());
        end
        dispatched += int'(dis_count);
        for (int i = 0; i < int'(in_count); i++) begin
            ib_op.push_back(in_opcode[i]);
            ib_dst.push_back(int'(in_dest[i]));
            ib_s1.push_back(int'(in_src1[i]));
            ib_s2.push_back(int'(in_src2[i]));
        end
        accepted += int'(in_count);
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int  rate;
        int  waited;
        bit  starved;

        rng_state = 96;
        errors = 0;
        checks = 0;
        accepted = 0;
        dispatched = 0;
        retired = 0;
        pops = 0;
        saw_full = 1'b0;
        saw_stall = 1'b0;
        rate = 50;
        reset = 1'b1;
        in_count = '0;
        for (int i = 0; i < width; i++)
            in_opcode[i] = op_alu;
        in_dest = '0;
        in_src1 = '0;
        in_src2 = '0;
        complete_valid = '0;
        complete_rob_idx = '0;
        for (int r = 0; r < arch_regs; r++)
            model_map[r] = r;                            // identity after reset
        for (int p = arch_regs; p < phys_regs; p++)
            free_q.push_back(p);
        rob_tail = 0;

        repeat (2) @(posedge clock);
        #2 reset = 1'b0;
        #18;
        check_value("dis_count", dis_count, 0);
        check_value("ret_count", ret_count, 0);
        check_value("ib_open", ib_open, width);

        for (int cyc = 0; cyc < run_cycles; cyc++) begin
            @(posedge clock);
            #2;
            if (cyc % 100 == 0)
                rate = 10 + int'(xorshift32() % 80);     // new completion rate
            starved = (cyc >= 800 && cyc < 1000);        // hold off the cdb
            drive_inputs(1'b1, starved ? 0 : rate);
            #18;
            if (starved && ib_open == '0)
                saw_full = 1'b1;
            check_and_step();
        end
        check_true(saw_full, "ib_open never fell to 0 while completions were held off");
        check_true(saw_stall, "dispatch never stalled with instructions waiting");

        // drain, no new input
        waited = 0;
        while ((rob_order.size() != 0 || ib_op.size() != 0) && waited < drain_limit) begin
            @(posedge clock);
            #2;
            drive_inputs(1'b0, 60);
            #18;
            check_and_step();
            waited++;
        end
        check_true(rob_order.size() == 0 && ib_op.size() == 0,
                   "drain timed out with instructions still in flight");
        check_value("dispatched", dispatched, accepted);
        check_value("retired", retired, accepted);
        check_true(pops > phys_regs - arch_regs, "no recycled register was ever handed out");

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // watchdog, backs up the bounded loops
    initial begin
        #((run_cycles + drain_limit + 20) * 40);
        $display("Error: simulation ran past its time limit");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== source/rename_core.sv ====
// rename core: buffer, dispatch, map table, free list and rob of the r10k front end
`timescale 1ns/10ps

module rename_core import isa_pkg::*, ooo_pkg::*; #(
    parameter  int phys_regs = 16,
    parameter  int rob_depth = 8,
    parameter  int ib_depth  = 4,
    localparam int preg_w    = $clog2(phys_regs),
    localparam int idx_w     = $clog2(rob_depth)
) (
    input  logic                            clock,
    input  logic                            reset,
    // instruction group in
    input  count_t                          in_count,
    input  opcode_t   [width-1:0]           in_opcode,
    input  arch_idx_t [width-1:0]           in_dest,
    input  arch_idx_t [width-1:0]           in_src1,
    input  arch_idx_t [width-1:0]           in_src2,
    output count_t                          ib_open,
    // completion from the execution side
    input  logic      [width-1:0]           complete_valid,
    input  logic      [width-1:0][idx_w-1:0] complete_rob_idx,
    // dispatch group out
    output count_t                          dis_count,
    output opcode_t   [width-1:0]           dis_opcode,
    output logic      [width-1:0][preg_w-1:0] dis_phys_src1,
    output logic      [width-1:0][preg_w-1:0] dis_phys_src2,
    output logic      [width-1:0][preg_w-1:0] dis_phys_dest,
    output logic      [width-1:0][preg_w-1:0] dis_phys_old,
    output logic      [width-1:0][idx_w-1:0] dis_rob_idx,
    // retirement out
    output count_t                          ret_count,
    output logic      [width-1:0]           ret_has_dest,
    output arch_idx_t [width-1:0]           ret_arch_dest,
    output logic      [width-1:0][preg_w-1:0] ret_phys_dest,
    output logic      [width-1:0][preg_w-1:0] ret_phys_old
);

    count_t                  head_count;
    arch_idx_t [width-1:0]   head_dest, head_src1, head_src2;
    count_t                  rob_free, fl_avail;
    logic [width-1:0][preg_w-1:0] fl_reg;

    // head opcodes go straight out as the dispatch opcodes
    inst_buffer #(.ib_depth(ib_depth)) buffer (
        .clock(clock), .reset(reset),
        .in_count(in_count), .in_opcode(in_opcode), .in_dest(in_dest),
        .in_src1(in_src1), .in_src2(in_src2), .dis_count(dis_count),
        .ib_open(ib_open), .head_count(head_count), .head_opcode(dis_opcode),
        .head_dest(head_dest), .head_src1(head_src1), .head_src2(head_src2)
    );

    dispatch disp (
        .head_count(head_count), .head_opcode(dis_opcode),
        .rob_free(rob_free), .fl_avail(fl_avail), .dis_count(dis_count)
    );

    map_table #(.phys_regs(phys_regs)) map (
        .clock(clock), .reset(reset),
        .dis_count(dis_count), .head_opcode(dis_opcode), .head_dest(head_dest),
        .head_src1(head_src1), .head_src2(head_src2), .fl_reg(fl_reg),
        .dis_phys_src1(dis_phys_src1), .dis_phys_src2(dis_phys_src2),
        .dis_phys_dest(dis_phys_dest), .dis_phys_old(dis_phys_old)
    );

    free_list #(.phys_regs(phys_regs)) fl (
        .clock(clock), .reset(reset),
        .dis_count(dis_count), .head_opcode(dis_opcode),
        .ret_count(ret_count), .ret_has_dest(ret_has_dest), .ret_phys_old(ret_phys_old),
        .fl_reg(fl_reg), .fl_avail(fl_avail)
    );

    rob #(.rob_depth(rob_depth), .phys_regs(phys_regs)) reorder (
        .clock(clock), .reset(reset),
        .dis_count(dis_count), .head_opcode(dis_opcode), .head_dest(head_dest),
        .dis_phys_dest(dis_phys_dest), .dis_phys_old(dis_phys_old),
        .complete_valid(complete_valid), .complete_rob_idx(complete_rob_idx),
        .rob_free(rob_free), .dis_rob_idx(dis_rob_idx), .ret_count(ret_count),
        .ret_has_dest(ret_has_dest), .ret_arch_dest(ret_arch_dest),
        .ret_phys_dest(ret_phys_dest), .ret_phys_old(ret_phys_old)
    );

endmodule

// ==== source/rob.sv ====
// reorder buffer: rename results and done bits, in-order retirement at the head
`timescale 1ns/10ps

module rob import isa_pkg::*, ooo_pkg::*; #(
    parameter  int rob_depth = 8,
    parameter  int phys_regs = 16,
    localparam int preg_w    = $clog2(phys_regs),
    localparam int idx_w     = $clog2(rob_depth)
) (
    input  logic                            clock,
    input  logic                            reset,
    input  count_t                          dis_count,
    input  opcode_t   [width-1:0]           head_opcode,
    input  arch_idx_t [width-1:0]           head_dest,
    input  logic      [width-1:0][preg_w-1:0] dis_phys_dest,
    input  logic      [width-1:0][preg_w-1:0] dis_phys_old,
    input  logic      [width-1:0]           complete_valid,     // cdb stand-in
    input  logic      [width-1:0][idx_w-1:0] complete_rob_idx,
    output count_t                          rob_free,
    output logic      [width-1:0][idx_w-1:0] dis_rob_idx,
    output count_t                          ret_count,
    output logic      [width-1:0]           ret_has_dest,
    output arch_idx_t [width-1:0]           ret_arch_dest,
    output logic      [width-1:0][preg_w-1:0] ret_phys_dest,
    output logic      [width-1:0][preg_w-1:0] ret_phys_old
);

    ////////////////////////////////////////////////////
    // entry state

    logic              entry_valid [rob_depth];           // control, reset
    logic              entry_done  [rob_depth];
    logic              entry_has_dest [rob_depth];        // payload from here down
    arch_idx_t         entry_arch  [rob_depth];
    logic [preg_w-1:0] entry_pdest [rob_depth];
    logic [preg_w-1:0] entry_pold  [rob_depth];

    logic [idx_w-1:0]  head_ptr, tail_ptr;
    logic [idx_w:0]    occupancy;
    logic [idx_w:0]    free_entries;

    assign free_entries = (idx_w+1)'(rob_depth) - occupancy;
    assign rob_free     = (free_entries >= width) ? count_t'(width) : count_t'(free_entries);

    ////////////////////////////////////////////////////
    // tail indices and retire view

    always_comb begin
        logic stop;

        stop      = 1'b0;
        ret_count = '0;
        for (int i = 0; i < width; i++) begin
            dis_rob_idx[i]   = tail_ptr + idx_w'(i);
            ret_has_dest[i]  = entry_has_dest[head_ptr + idx_w'(i)];
            ret_arch_dest[i] = entry_arch[head_ptr + idx_w'(i)];
            ret_phys_dest[i] = entry_pdest[head_ptr + idx_w'(i)];
            ret_phys_old[i]  = entry_pold[head_ptr + idx_w'(i)];
            // done prefix only, an unfinished entry holds back the rest
            if (!entry_valid[head_ptr + idx_w'(i)] || !entry_done[head_ptr + idx_w'(i)])
                stop = 1'b1;
            if (!stop)
                ret_count = ret_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < rob_depth; e++) begin
                entry_valid[e] <= 1'b0;
                entry_done[e]  <= 1'b0;
            end
            head_ptr  <= '0;
            tail_ptr  <= '0;
            occupancy <= '0;
        end else begin
            for (int i = 0; i < width; i++) begin
                if (i < int'(dis_count)) begin           // new entry at tail
                    entry_valid[dis_rob_idx[i]]    <= 1'b1;
                    entry_done[dis_rob_idx[i]]     <= 1'b0;
                    entry_has_dest[dis_rob_idx[i]] <= writes_dest(head_opcode[i]);
                    entry_arch[dis_rob_idx[i]]     <= head_dest[i];
                    entry_pdest[dis_rob_idx[i]]    <= dis_phys_dest[i];
                    entry_pold[dis_rob_idx[i]]     <= dis_phys_old[i];
                end
                if (complete_valid[i])
                    entry_done[complete_rob_idx[i]] <= 1'b1;   // any order
                if (i < int'(ret_count))
                    entry_valid[head_ptr + idx_w'(i)] <= 1'b0;
            end
            tail_ptr  <= tail_ptr + idx_w'(dis_count);
            head_ptr  <= head_ptr + idx_w'(ret_count);
            occupancy <= occupancy + (idx_w+1)'(dis_count) - (idx_w+1)'(ret_count);
        end
    end

    // completion only for instructions in flight
    for (genvar g = 0; g < width; g++) begin : g_complete_chk
        a_complete_live: assert property (@(posedge clock) disable iff (reset)
            complete_valid[g] |-> entry_valid[complete_rob_idx[g]]);
    end

endmodule

// ==== source/free_list.sv ====
// free list: circular queue of free phys regs, popped at dispatch, refilled at retire
`timescale 1ns/10ps

module free_list import isa_pkg::*, ooo_pkg::*; #(
    parameter  int phys_regs = 16,
    localparam int preg_w    = $clog2(phys_regs)
) (
    input  logic                          clock,
    input  logic                          reset,
    input  count_t                        dis_count,
    input  opcode_t [width-1:0]           head_opcode,
    input  count_t                        ret_count,
    input  logic    [width-1:0]           ret_has_dest,
    input  logic    [width-1:0][preg_w-1:0] ret_phys_old,   // told back to the pool
    output logic    [width-1:0][preg_w-1:0] fl_reg,
    output count_t                        fl_avail
);

    localparam int fl_depth = phys_regs - arch_regs;     // not always 2^n
    localparam int ptr_w    = $clog2(fl_depth);
    localparam int cnt_w    = $clog2(fl_depth + 1);

    logic [preg_w-1:0] regs [fl_depth];
    logic [ptr_w-1:0]  head_ptr, tail_ptr;
    logic [cnt_w-1:0]  count;

    int pop_n;
    int push_n;
    logic [width-1:0][ptr_w-1:0] push_addr;

    // pointer step with explicit wrap
    function automatic logic [ptr_w-1:0] adv(logic [ptr_w-1:0] p, int n);
        int s;
        s = int'(p) + n;
        if (s >= fl_depth)
            s = s - fl_depth;
        return ptr_w'(s);
    endfunction

    assign fl_avail = (count >= width) ? count_t'(width) : count_t'(count);

    always_comb begin
        pop_n  = 0;
        push_n = 0;
        for (int i = 0; i < width; i++) begin
            fl_reg[i]    = regs[adv(head_ptr, i)];
            push_addr[i] = adv(tail_ptr, push_n);
            if (i < int'(dis_count) && writes_dest(head_opcode[i]))
                pop_n = pop_n + 1;
            if (i < int'(ret_count) && ret_has_dest[i])
                push_n = push_n + 1;                     // packs pushes in slot order
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < fl_depth; i++)
                regs[i] <= preg_w'(arch_regs + i);       // regs above the arch set
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= cnt_w'(fl_depth);                // starts full
        end else begin
            for (int i = 0; i < width; i++) begin
                if (i < int'(ret_count) && ret_has_dest[i])
                    regs[push_addr[i]] <= ret_phys_old[i];
            end
            head_ptr <= adv(head_ptr, pop_n);
            tail_ptr <= adv(tail_ptr, push_n);
            count    <= count + cnt_w'(push_n) - cnt_w'(pop_n);
        end
    end

    // retirement never returns more regs than dispatch took
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        int'(count) + push_n - pop_n <= fl_depth);

endmodule

// ==== source/map_table.sv ====
// map table: speculative arch to phys map with bypass inside the dispatch group
`timescale 1ns/10ps

module map_table import isa_pkg::*, ooo_pkg::*; #(
    parameter  int phys_regs = 16,
    localparam int preg_w    = $clog2(phys_regs)
) (
    input  logic                         clock,
    input  logic                         reset,
    input  count_t                       dis_count,
    input  opcode_t   [width-1:0]        head_opcode,
    input  arch_idx_t [width-1:0]        head_dest,
    input  arch_idx_t [width-1:0]        head_src1,
    input  arch_idx_t [width-1:0]        head_src2,
    input  logic      [width-1:0][preg_w-1:0] fl_reg,       // free list head pair
    output logic      [width-1:0][preg_w-1:0] dis_phys_src1,
    output logic      [width-1:0][preg_w-1:0] dis_phys_src2,
    output logic      [width-1:0][preg_w-1:0] dis_phys_dest,
    output logic      [width-1:0][preg_w-1:0] dis_phys_old  // told
);

    logic [preg_w-1:0] map [arch_regs];

    ////////////////////////////////////////////////////
    // new tags and lookups

    always_comb begin
        int take;                                        // next free list slot

        take = 0;
        for (int i = 0; i < width; i++) begin
            dis_phys_dest[i] = '0;
            if (writes_dest(head_opcode[i])) begin
                dis_phys_dest[i] = fl_reg[take];         // producers in slot order
                take = take + 1;
            end

            dis_phys_src1[i] = map[head_src1[i]];
            dis_phys_src2[i] = map[head_src2[i]];
            dis_phys_old[i]  = map[head_dest[i]];

            // older slot in the group renamed it already, youngest match wins
            for (int j = 0; j < i; j++) begin
                if (writes_dest(head_opcode[j])) begin
                    if (head_src1[i] == head_dest[j]) dis_phys_src1[i] = dis_phys_dest[j];
                    if (head_src2[i] == head_dest[j]) dis_phys_src2[i] = dis_phys_dest[j];
                    if (head_dest[i] == head_dest[j]) dis_phys_old[i]  = dis_phys_dest[j];
                end
            end
        end
    end

    ////////////////////////////////////////////////////
    // commit new mappings

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_regs; r++)
                map[r] <= preg_w'(r);                    // identity map
        end else begin
            for (int i = 0; i < width; i++) begin
                // later slot overrides on same dest
                if (i < int'(dis_count) && writes_dest(head_opcode[i]))
                    map[head_dest[i]] <= dis_phys_dest[i];
            end
        end
    end

endmodule

// ==== source/dispatch.sv ====
// dispatch limit: in-order count of head instructions that fit in rob and free list
`timescale 1ns/10ps

module dispatch import isa_pkg::*, ooo_pkg::*; (
    input  logic [$clog2(width+1)-1:0] head_count,    // valid head slots
    input  opcode_t [width-1:0]        head_opcode,
    input  count_t                     rob_free,      // rob entries, capped
    input  count_t                     fl_avail,      // free regs, capped
    output count_t                     dis_count
);

    ////////////////////////////////////////////////////
    // in-order walk of the head slots

    always_comb begin
        int   rob_need;
        int   reg_need;
        logic blocked;

        rob_need  = 0;
        reg_need  = 0;
        blocked   = 1'b0;
        dis_count = '0;

        for (int i = 0; i < width; i++) begin
            if (i >= int'(head_count))
                blocked = 1'b1;                          // slot empty
            rob_need = rob_need + 1;                     // every slot takes an entry
            if (writes_dest(head_opcode[i]))
                reg_need = reg_need + 1;                 // only producers need a reg
            if (rob_need > int'(rob_free))
                blocked = 1'b1;
            if (reg_need > int'(fl_avail))
                blocked = 1'b1;
            // first miss stops the group, younger slots wait
            if (!blocked)
                dis_count = dis_count + 1'b1;
        end
    end

endmodule

// ==== source/inst_buffer.sv ====
// instruction buffer: circular queue of undispatched instructions, group in, counted out
`timescale 1ns/10ps

module inst_buffer import isa_pkg::*, ooo_pkg::*; #(
    parameter int ib_depth = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  count_t                in_count,      // valid input slots
    input  opcode_t   [width-1:0] in_opcode,
    input  arch_idx_t [width-1:0] in_dest,
    input  arch_idx_t [width-1:0] in_src1,
    input  arch_idx_t [width-1:0] in_src2,
    input  count_t                dis_count,     // slots leaving this cycle
    output count_t                ib_open,
    output count_t                head_count,
    output opcode_t   [width-1:0] head_opcode,
    output arch_idx_t [width-1:0] head_dest,
    output arch_idx_t [width-1:0] head_src1,
    output arch_idx_t [width-1:0] head_src2
);

    localparam int ptr_w = $clog2(ib_depth);

    // payload storage
    opcode_t   buf_opcode [ib_depth];
    arch_idx_t buf_dest   [ib_depth];
    arch_idx_t buf_src1   [ib_depth];
    arch_idx_t buf_src2   [ib_depth];

    logic [ptr_w-1:0] head_ptr, tail_ptr;        // wrap naturally, depth is 2^n
    logic [ptr_w:0]   occupancy;
    logic [ptr_w:0]   free_entries;

    assign free_entries = (ptr_w+1)'(ib_depth) - occupancy;

    // both counts capped at a group
    assign ib_open    = (free_entries >= width) ? count_t'(width) : count_t'(free_entries);
    assign head_count = (occupancy >= width) ? count_t'(width) : count_t'(occupancy);

    always_comb begin
        for (int i = 0; i < width; i++) begin
            head_opcode[i] = buf_opcode[head_ptr + ptr_w'(i)];
            head_dest[i]   = buf_dest[head_ptr + ptr_w'(i)];
            head_src1[i]   = buf_src1[head_ptr + ptr_w'(i)];
            head_src2[i]   = buf_src2[head_ptr + ptr_w'(i)];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            occupancy <= '0;
        end else begin
            for (int i = 0; i < width; i++) begin
                if (i < int'(in_count)) begin            // slot i is valid
                    buf_opcode[tail_ptr + ptr_w'(i)] <= in_opcode[i];
                    buf_dest[tail_ptr + ptr_w'(i)]   <= in_dest[i];
                    buf_src1[tail_ptr + ptr_w'(i)]   <= in_src1[i];
                    buf_src2[tail_ptr + ptr_w'(i)]   <= in_src2[i];
                end
            end
            tail_ptr  <= tail_ptr + ptr_w'(in_count);
            head_ptr  <= head_ptr + ptr_w'(dis_count);
            occupancy <= occupancy + (ptr_w+1)'(in_count) - (ptr_w+1)'(dis_count);
        end
    end

    // producer honours the open count
    a_no_overfill: assert property (@(posedge clock) disable iff (reset)
        in_count <= ib_open);

    // dispatch never takes more than is present
    a_no_overdrain: assert property (@(posedge clock) disable iff (reset)
        dis_count <= head_count);

endmodule

// ==== source/ooo_pkg.sv ====
// out-of-order machine constants: superscalar width and slot count type

package ooo_pkg;

    ////////////////////////////////////////////////////
    // machine width

    // two-wide front end, the slot logic is written for two
    localparam int width = 2;

    ////////////////////////////////////////////////////
    // counts

    // number of slots in a group, 0..width
    typedef logic [$clog2(width+1)-1:0] count_t;

endpackage

// ==== source/isa_pkg.sv ====
// isa types: opcodes, architectural register index and the destination rule
package isa_pkg;

    // opcode classes seen by rename
    typedef enum logic [2:0] {
        op_alu,
        op_mul,
        op_load,
        op_store,
        op_branch
    } opcode_t;

    localparam int arch_regs = 8;               // r0..r7

    typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;

    // stores and branches produce no register result
    function automatic logic writes_dest(opcode_t op);
        case (op)
            op_alu,
            op_mul,
            op_load: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage
